// ==== files.f ====
+incdir+src
src/eth_rx_pkg.sv
src/hdr_filter.sv
src/conn_table.sv
src/payload_realign.sv
src/eth_rx_top.sv
testbench/eth_rx_chk.sv
testbench/eth_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the eth_rx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module eth_rx_tb -o eth_rx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/eth_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
exit 0

// ==== testbench/eth_rx_tb.sv ====
`timescale 1ns/100ps
`include "eth_rx_consts.svh"

module eth_rx_tb
  import eth_rx_pkg::*;
();

  localparam int NB = `ETH_BUS_BYTES;
  localparam int NH = `ETH_HDR_BYTES;

  logic       aclk;
  logic       aresetn;
  logic       in_valid;
  rx_beat_t   in_beat;
  conn_cfg_t  cfg;
  logic       ctrl_valid;
  ctrl_req_t  ctrl_req;
  logic       ctrl_resp_valid;
  ctrl_resp_t ctrl_resp;
  logic       out_valid;
  pay_beat_t  out_beat;

  // ------------------------------------------------------------
  // testbench state
  // ------------------------------------------------------------
  logic [31:0]              rng = 32'd63;
  // beats of the packet being sent
  rx_beat_t                 pkt[$];
  pay_beat_t                exp_q[$];
  ctrl_resp_t               resp_q[$];
  // model of the connection table
  conn_key_t                tbl_key [`CONN_ENTRIES];
  logic [`CONN_ENTRIES-1:0] tbl_used;
  int                       n_beats;
  int                       n_resps;
  int                       n_mismatch;
  int                       n_stray;
  int                       n_timeout;

  eth_rx_top dut_i (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .in_valid        (in_valid),
    .in_beat         (in_beat),
    .cfg             (cfg),
    .ctrl_valid      (ctrl_valid),
    .ctrl_req        (ctrl_req),
    .ctrl_resp_valid (ctrl_resp_valid),
    .ctrl_resp       (ctrl_resp),
    .out_valid       (out_valid),
    .out_beat        (out_beat)
  );

  // 8 ns clock
  initial begin
    aclk = 1'b0;
    forever begin
      #4 aclk = ~aclk;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
  endfunction

  // live keys after the table phase: 0..4, 6, 7, and 8 sitting in slot 5
  function automatic int pick_src();
    int k;
    k = rand_below(8);
    return (k == 5) ? 8 : k;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  // expected output beats for the packet held in pkt
  function automatic void exp_stream();
    logic [NH*8-1:0] hdr;
    logic [7:0]      pay[$];
    rx_beat_t        h;
    pay_beat_t       o;
    logic            hit;
    conn_id_t        id;
    logic            len_ok;
    int              nout;
    h   = pkt[0];
    hit = 1'b0;
    id  = '0;
    // lane 0 is the top byte of the header vector
    for (int l = 0; l < NH; l++) begin
      hdr[8*(NH-1-l) +: 8] = h.data[l];
    end
    // dst mac, ethertype, version, protocol, dst ip, dst port, strobes
    if (hdr[335:288] != cfg.mac || hdr[239:224] != 16'h0800 || hdr[223:220] != 4'd4 ||
        hdr[151:144] != 8'd17 || hdr[95:64] != cfg.ip || hdr[47:32] != cfg.port ||
        !(&h.strb[NH-1:0])) begin
      return;
    end
    // source ip and port against the table model
    for (int i = 0; i < `CONN_ENTRIES; i++) begin
      if (tbl_used[i] && tbl_key[i] == {hdr[127:96], hdr[63:48]}) begin
        hit = 1'b1;
        id  = conn_id_t'(i);
      end
    end
    if (!hit) begin
      return;
    end
    // payload bytes in wire order
    foreach (pkt[k]) begin
      for (int l = (k == 0) ? NH : 0; l < NB; l++) begin
        if (pkt[k].strb[l]) begin
          pay.push_back(pkt[k].data[l]);
        end
      end
    end
    len_ok = 16'(pay.size()) == hdr[31:16] - 16'd8;
    // an empty payload still ends with one beat
    nout = (pay.size() + NB - 1) / NB;
    if (nout == 0) begin
      nout = 1;
    end
    for (int j = 0; j < nout; j++) begin
      o = '0;
      for (int l = 0; l < NB; l++) begin
        if (j * NB + l < pay.size()) begin
          o.data[l] = pay[j * NB + l];
          o.strb[l] = 1'b1;
        end
      end
      o.last      = (j == nout - 1);
      o.conn_id   = id;
      o.length_ok = o.last && len_ok;
      exp_q.push_back(o);
    end
  endfunction

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  // fault 0 none, 1 mac, 2 ip, 3 port, 4 ethertype, 5 version, 6 protocol, 7 strobe
  task automatic send_pkt(input conn_key_t src, input int pay_bytes, input int fault,
                          input int len_adj);
    logic [NH*8-1:0] hdr;
    rx_beat_t        b;
    int              total;
    total = NH + pay_bytes;
    hdr = {cfg.mac ^ 48'(fault == 1), 48'h02_00_00_00_00_01, 16'h0800 ^ 16'(fault == 4),
           (fault == 5) ? 8'h65 : 8'h45, 8'h00, 16'(total - 14), 16'h0000, 16'h4000,
           8'h40, 8'd17 ^ 8'(fault == 6), 16'h0000,
           src.ip, cfg.ip ^ 32'(fault == 2), src.port, cfg.port ^ 16'(fault == 3),
           16'(pay_bytes + `ETH_UDP_HDR_BYTES + len_adj), 16'h0000};
    pkt.delete();
    for (int k = 0; k * NB < total; k++) begin
      for (int l = 0; l < NB; l++) begin
        b.data[l] = (k == 0 && l < NH) ? hdr[8*(NH-1-l) +: 8] : 8'(next_rand());
        b.strb[l] = (k * NB + l) < total;
      end
      b.last = (k + 1) * NB >= total;
      pkt.push_back(b);
    end
    if (fault == 7) begin
      b = pkt[0];
      b.strb[rand_below(NH)] = 1'b0;
      pkt[0] = b;
    end
    exp_stream();
    // beats back to back, next packet may follow at once
    foreach (pkt[k]) begin
      in_beat  = pkt[k];
      in_valid = 1'b1;
      @(posedge aclk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  // wait until all expected results are seen, then a few quiet cycles
  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || resp_q.size() != 0) && n < 100) begin
      @(posedge aclk);
      #1;
      n++;
    end
    if (exp_q.size() != 0 || resp_q.size() != 0) begin
      n_timeout++;
      $display("timeout, %0d output beats and %0d responses never arrived",
               exp_q.size(), resp_q.size());
      exp_q.delete();
      resp_q.delete();
    end
    repeat (4) begin
      @(posedge aclk);
    end
    #1;
  endtask

  // table request, expected answer from the model
  task automatic ctrl_op(input conn_key_t key, input logic act);
    ctrl_resp_t r;
    int         slot;
    int         free_slot;
    slot      = -1;
    free_slot = -1;
    for (int i = `CONN_ENTRIES - 1; i >= 0; i--) begin
      if (tbl_used[i] && tbl_key[i] == key) begin
        slot = i;
      end
      if (!tbl_used[i]) begin
        free_slot = i;
      end
    end
    if (act) begin
      r.ack  = (slot >= 0) || (free_slot >= 0);
      r.full = !r.ack;
      if (slot < 0 && free_slot >= 0) begin
        tbl_used[free_slot] = 1'b1;
        tbl_key[free_slot]  = key;
      end
    end else begin
      r.ack  = slot >= 0;
      r.full = 1'b0;
      if (slot >= 0) begin
        tbl_used[slot] = 1'b0;
      end
    end
    resp_q.push_back(r);
    ctrl_req.key      = key;
    ctrl_req.activate = act;
    ctrl_valid        = 1'b1;
    @(posedge aclk);
    #1;
    ctrl_valid = 1'b0;
    drain();
  endtask

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic check_beat(input pay_beat_t exp, input pay_beat_t got);
    logic [NB*8-1:0] mask;
    for (int l = 0; l < NB; l++) begin
      mask[8*l +: 8] = {8{exp.strb[l]}};
    end
    n_beats++;
    // unstrobed lanes carry no payload
    if ((got.data & mask) !== (exp.data & mask)) begin
      n_mismatch++;
      $display("mismatch out_beat.data exp %h got %h", exp.data & mask, got.data & mask);
    end
    if (got.strb !== exp.strb) begin
      n_mismatch++;
      $display("mismatch out_beat.strb exp %h got %h", exp.strb, got.strb);
    end
    if (got.last !== exp.last) begin
      n_mismatch++;
      $display("mismatch out_beat.last exp %h got %h", exp.last, got.last);
    end
    if (got.conn_id !== exp.conn_id) begin
      n_mismatch++;
      $display("mismatch out_beat.conn_id exp %h got %h", exp.conn_id, got.conn_id);
    end
    if (got.length_ok !== exp.length_ok) begin
      n_mismatch++;
      $display("mismatch out_beat.length_ok exp %h got %h", exp.length_ok, got.length_ok);
    end
  endtask

  task automatic check_resp(input ctrl_resp_t exp, input ctrl_resp_t got);
    n_resps++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch ctrl_resp exp %h got %h", exp, got);
    end
  endtask

  // outputs sampled mid cycle
  initial begin
    forever begin
      @(negedge aclk);
      if (aresetn && out_valid) begin
        if (exp_q.size() == 0) begin
          n_stray++;
          $display("output beat at %0t while no beat was expected", $time);
        end else begin
          check_beat(exp_q.pop_front(), out_beat);
        end
      end
      if (aresetn && ctrl_resp_valid) begin
        if (resp_q.size() == 0) begin
          n_stray++;
          $display("table response at %0t without a request", $time);
        end else begin
          check_resp(resp_q.pop_front(), ctrl_resp);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    conn_key_t keys [10];
    in_valid   = 1'b0;
    in_beat    = '0;
    ctrl_valid = 1'b0;
    ctrl_req   = '0;
    cfg.mac    = 48'h02_1a_2b_3c_4d_5e;
    cfg.ip     = 32'hc0a8_0114;
    cfg.port   = 16'd4791;
    tbl_used   = '0;
    aresetn    = 1'b0;
    for (int i = 0; i < 10; i++) begin
      keys[i].ip   = next_rand();
      keys[i].port = 16'(next_rand());
    end
    repeat (10) begin
      @(posedge aclk);
    end
    #1;
    aresetn = 1'b1;

    // fill, overflow, remove twice, repeat add with a slot free, reuse the slot
    for (int i = 0; i < 8; i++) begin
      ctrl_op(keys[i], 1'b1);
    end
    ctrl_op(keys[8], 1'b1);
    ctrl_op(keys[5], 1'b0);
    ctrl_op(keys[5], 1'b0);
    ctrl_op(keys[3], 1'b1);
    ctrl_op(keys[8], 1'b1);

    // accepted packets of 1 to 5 beats, one at a time
    for (int i = 0; i < 24; i++) begin
      send_pkt(keys[pick_src()], rand_below(279), 0, 0);
      drain();
    end

    // each header fault is dropped
    for (int f = 1; f <= 7; f++) begin
      send_pkt(keys[0], 30 * f, f, 0);
      drain();
    end

    // never added and removed sources
    send_pkt(keys[9], 50, 0, 0);
    send_pkt(keys[5], 50, 0, 0);
    drain();

    // udp length off by a few bytes
    send_pkt(keys[1], 100, 0, 3);
    send_pkt(keys[2], 20, 0, -2);
    drain();

    // back to back, single beats right behind each other
    send_pkt(keys[4], 10, 0, 0);
    send_pkt(keys[6], 0, 0, 0);
    send_pkt(keys[7], 200, 0, 0);
    send_pkt(keys[0], 50, 3, 0);
    send_pkt(keys[8], 22, 0, 0);
    for (int i = 0; i < 12; i++) begin
      send_pkt(keys[pick_src()], rand_below(279), (rand_below(4) == 0) ? 7 : 0, 0);
    end
    drain();

    $display("beats %0d, responses %0d, mismatches %0d, stray %0d, timeouts %0d",
             n_beats, n_resps, n_mismatch, n_stray, n_timeout);
    if (n_mismatch == 0 && n_stray == 0 && n_timeout == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/eth_rx_chk.sv ====
`timescale 1ns/100ps

module eth_rx_chk
  import eth_rx_pkg::*;
(
  input logic       aclk,
  input logic       aresetn,
  input logic       ctrl_valid,
  input logic       ctrl_resp_valid,
  input ctrl_resp_t ctrl_resp,
  input logic       out_valid,
  input pay_beat_t  out_beat
);

  // response exactly one cycle after each request
  resp_timing: assert property (@(posedge aclk) disable iff (!aresetn)
    ctrl_resp_valid == $past(ctrl_valid))
    else $error("ctrl_resp_valid does not follow ctrl_valid by one cycle");

  resp_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    !(ctrl_resp.ack && ctrl_resp.full))
    else $error("ctrl_resp has ack and full set together");

  // no output while held in reset
  reset_quiet: assert property (@(posedge aclk) !aresetn |=> !out_valid)
    else $error("out_valid high during reset");

  // only the closing beat may be partial
  full_mid_beat: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_beat.last |-> &out_beat.strb)
    else $error("out_beat without last has missing strobes");

endmodule

bind eth_rx_top eth_rx_chk chk_i (
  .aclk            (aclk),
  .aresetn         (aresetn),
  .ctrl_valid      (ctrl_valid),
  .ctrl_resp_valid (ctrl_resp_valid),
  .ctrl_resp       (ctrl_resp),
  .out_valid       (out_valid),
  .out_beat        (out_beat)
);

// ==== src/eth_rx_top.sv ====
`timescale 1ns/100ps

module eth_rx_top
  import eth_rx_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  // receive stream, always accepted
  input  logic       in_valid,
  input  rx_beat_t   in_beat,
  // own addressing
  input  conn_cfg_t  cfg,
  // connection table control
  input  logic       ctrl_valid,
  input  ctrl_req_t  ctrl_req,
  output logic       ctrl_resp_valid,
  output ctrl_resp_t ctrl_resp,
  // realigned payload
  output logic       out_valid,
  output pay_beat_t  out_beat
);

  logic        hdr_ok;
  conn_key_t   src_key;
  logic [15:0] pay_len;
  logic        lookup_hit;
  conn_id_t    lookup_id;

  // ------------------------------------------------------------
  // header checks and source lookup, same cycle as the beat
  // ------------------------------------------------------------
  hdr_filter hdr_filter_i (
    .beat    (in_beat),
    .cfg     (cfg),
    .hdr_ok  (hdr_ok),
    .src_key (src_key),
    .pay_len (pay_len)
  );

  conn_table conn_table_i (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .ctrl_valid      (ctrl_valid),
    .ctrl_req        (ctrl_req),
    .ctrl_resp_valid (ctrl_resp_valid),
    .ctrl_resp       (ctrl_resp),
    .lookup_key      (src_key),
    .lookup_hit      (lookup_hit),
    .lookup_id       (lookup_id)
  );

  // shift payload to lane 0
  payload_realign payload_realign_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .hdr_ok     (hdr_ok),
    .lookup_hit (lookup_hit),
    .lookup_id  (lookup_id),
    .pay_len    (pay_len),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

endmodule

// ==== src/payload_realign.sv ====
`timescale 1ns/100ps
`include "eth_rx_consts.svh"

module payload_realign
  import eth_rx_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        in_valid,
  input  rx_beat_t    in_beat,
  input  logic        hdr_ok,
  input  logic        lookup_hit,
  input  conn_id_t    lookup_id,
  input  logic [15:0] pay_len,
  output logic        out_valid,
  output pay_beat_t   out_beat
);

  typedef enum logic {
    ST_IDLE,
    ST_PKT
  } state_t;

  state_t state;
  logic   prev_last;
  logic   flush_pend;

  // upper lanes of the previous beat, payload still to be sent
  logic [`ETH_LEFT_BYTES-1:0][7:0] left_data;
  logic [`ETH_LEFT_BYTES-1:0]      left_strb;
  logic [15:0]                     exp_len;
  logic [15:0]                     byte_cnt;
  conn_id_t                        conn_id_q;

  logic        first_beat;
  logic        accept;
  logic        mid_beat;
  logic        tail_strb;
  logic [6:0]  beat_bytes;
  logic [15:0] cnt_sum;

  // ------------------------------------------------------------
  // beat classification
  // ------------------------------------------------------------
  assign first_beat = in_valid && prev_last;
  assign accept     = first_beat && hdr_ok && lookup_hit;
  // in ST_PKT every beat is a continuation
  assign mid_beat   = (state == ST_PKT) && in_valid;
  // bytes past the header lanes need one more output beat
  assign tail_strb  = |in_beat.strb[`ETH_BUS_BYTES-1:`ETH_HDR_BYTES];
  assign beat_bytes = 7'($countones(in_beat.strb));
  assign cnt_sum    = byte_cnt + 16'(beat_bytes);

  // ------------------------------------------------------------
  // packet state
  // ------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= ST_IDLE;
      prev_last  <= 1'b1;
      flush_pend <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      if (in_valid) begin
        prev_last <= in_beat.last;
      end
      // flush and continuation never fall in the same cycle
      out_valid  <= flush_pend || mid_beat;
      flush_pend <= (accept && in_beat.last) ||
                    (mid_beat && in_beat.last && tail_strb);
      case (state)
        ST_IDLE: begin
          if (accept && !in_beat.last) begin
            state <= ST_PKT;
          end
        end
        default: begin
          if (mid_beat && in_beat.last) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  always_ff @(posedge aclk) begin
    // per-packet context from the first beat
    if (accept) begin
      left_data <= in_beat.data[`ETH_BUS_BYTES-1:`ETH_HDR_BYTES];
      left_strb <= in_beat.strb[`ETH_BUS_BYTES-1:`ETH_HDR_BYTES];
      byte_cnt  <= 16'(beat_bytes) - 16'(`ETH_HDR_BYTES);
      exp_len   <= pay_len;
      conn_id_q <= lookup_id;
    end else if (mid_beat) begin
      left_data <= in_beat.data[`ETH_BUS_BYTES-1:`ETH_HDR_BYTES];
      left_strb <= in_beat.strb[`ETH_BUS_BYTES-1:`ETH_HDR_BYTES];
      byte_cnt  <= cnt_sum;
    end

    if (flush_pend) begin
      // stored bytes alone, reads the context before a new accept lands
      out_beat.data[`ETH_LEFT_BYTES-1:0]              <= left_data;
      out_beat.data[`ETH_BUS_BYTES-1:`ETH_LEFT_BYTES] <= '0;
      out_beat.strb[`ETH_LEFT_BYTES-1:0]              <= left_strb;
      out_beat.strb[`ETH_BUS_BYTES-1:`ETH_LEFT_BYTES] <= '0;
      out_beat.last      <= 1'b1;
      out_beat.length_ok <= (byte_cnt == exp_len);
      out_beat.conn_id   <= conn_id_q;
    end else if (mid_beat) begin
      // stored bytes first, then header lanes of this beat
      out_beat.data[`ETH_LEFT_BYTES-1:0]              <= left_data;
      out_beat.data[`ETH_BUS_BYTES-1:`ETH_LEFT_BYTES] <= in_beat.data[`ETH_HDR_BYTES-1:0];
      out_beat.strb[`ETH_LEFT_BYTES-1:0]              <= left_strb;
      out_beat.strb[`ETH_BUS_BYTES-1:`ETH_LEFT_BYTES] <= in_beat.strb[`ETH_HDR_BYTES-1:0];
      out_beat.last      <= in_beat.last && !tail_strb;
      out_beat.length_ok <= in_beat.last && !tail_strb && (cnt_sum == exp_len);
      out_beat.conn_id   <= conn_id_q;
    end
  end

endmodule

// ==== src/conn_table.sv ====
`timescale 1ns/100ps
`include "eth_rx_consts.svh"

module conn_table
  import eth_rx_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       ctrl_valid,
  input  ctrl_req_t  ctrl_req,
  output logic       ctrl_resp_valid,
  output ctrl_resp_t ctrl_resp,
  input  conn_key_t  lookup_key,
  output logic       lookup_hit,
  output conn_id_t   lookup_id
);

  logic [`CONN_ENTRIES-1:0] used;
  conn_key_t                keys [`CONN_ENTRIES];

  logic     ctrl_hit;
  conn_id_t ctrl_idx;
  logic     free_hit;
  conn_id_t free_idx;
  logic     add_new;

  // ------------------------------------------------------------
  // slot search for control and lookup
  // ------------------------------------------------------------
  always_comb begin
    ctrl_hit   = 1'b0;
    ctrl_idx   = '0;
    lookup_hit = 1'b0;
    lookup_id  = '0;
    for (int i = 0; i < `CONN_ENTRIES; i++) begin
      // a key lives in one slot at most
      if (used[i] && keys[i] == ctrl_req.key) begin
        ctrl_hit = 1'b1;
        ctrl_idx = conn_id_t'(i);
      end
      if (used[i] && keys[i] == lookup_key) begin
        lookup_hit = 1'b1;
        lookup_id  = conn_id_t'(i);
      end
    end
    // walk downwards so the lowest free slot wins
    free_hit = 1'b0;
    free_idx = '0;
    for (int i = `CONN_ENTRIES - 1; i >= 0; i--) begin
      if (!used[i]) begin
        free_hit = 1'b1;
        free_idx = conn_id_t'(i);
      end
    end
  end

  // new key with room for it
  assign add_new = ctrl_valid && ctrl_req.activate && !ctrl_hit && free_hit;

  // ------------------------------------------------------------
  // updates and registered response
  // ------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      used            <= '0;
      ctrl_resp_valid <= 1'b0;
      ctrl_resp       <= '0;
    end else begin
      ctrl_resp_valid <= ctrl_valid;
      if (ctrl_valid) begin
        if (ctrl_req.activate) begin
          // present already, or stored now, or no room
          ctrl_resp.ack  <= ctrl_hit || free_hit;
          ctrl_resp.full <= !ctrl_hit && !free_hit;
          if (add_new) begin
            used[free_idx] <= 1'b1;
          end
        end else begin
          // remove, nack when the key is absent
          ctrl_resp.ack  <= ctrl_hit;
          ctrl_resp.full <= 1'b0;
          if (ctrl_hit) begin
            used[ctrl_idx] <= 1'b0;
          end
        end
      end
    end
  end

  // key storage
  always_ff @(posedge aclk) begin
    if (add_new) begin
      keys[free_idx] <= ctrl_req.key;
    end
  end

endmodule

// ==== src/hdr_filter.sv ====
`timescale 1ns/100ps
`include "eth_rx_consts.svh"

module hdr_filter
  import eth_rx_pkg::*;
(
  input  rx_beat_t    beat,
  input  conn_cfg_t   cfg,
  output logic        hdr_ok,
  output conn_key_t   src_key,
  output logic [15:0] pay_len
);

  logic [47:0] dst_mac;
  logic [15:0] eth_type;
  logic [3:0]  ip_ver;
  logic [7:0]  ip_proto;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [15:0] udp_len;
  logic        strb_ok;

  // ------------------------------------------------------------
  // field extraction, big-endian across lanes
  // ------------------------------------------------------------
  // ethernet: dst mac 0..5, src mac 6..11, ethertype 12..13
  assign dst_mac  = {beat.data[0], beat.data[1], beat.data[2],
                     beat.data[3], beat.data[4], beat.data[5]};
  assign eth_type = {beat.data[12], beat.data[13]};
  // ipv4 starts at lane 14, version in the upper nibble
  assign ip_ver   = beat.data[14][7:4];
  assign ip_proto = beat.data[23];
  assign src_ip   = {beat.data[26], beat.data[27], beat.data[28], beat.data[29]};
  assign dst_ip   = {beat.data[30], beat.data[31], beat.data[32], beat.data[33]};
  // udp starts at lane 34, checksum in 40..41 is not used
  assign src_port = {beat.data[34], beat.data[35]};
  assign dst_port = {beat.data[36], beat.data[37]};
  assign udp_len  = {beat.data[38], beat.data[39]};

  // every header lane must carry a byte
  assign strb_ok = &beat.strb[`ETH_HDR_BYTES-1:0];

  // ------------------------------------------------------------
  // acceptance, qualified with first beat downstream
  // ------------------------------------------------------------
  assign hdr_ok = strb_ok &&
                  (dst_mac  == cfg.mac) &&
                  (eth_type == `ETH_TYPE_IPV4) &&
                  (ip_ver   == 4'd4) &&
                  (ip_proto == `ETH_PROTO_UDP) &&
                  (dst_ip   == cfg.ip) &&
                  (dst_port == cfg.port);

  // remote end goes to the connection lookup
  assign src_key.ip   = src_ip;
  assign src_key.port = src_port;

  // udp length counts its own 8-byte header
  assign pay_len = udp_len - 16'(`ETH_UDP_HDR_BYTES);

endmodule

// ==== src/eth_rx_pkg.sv ====
`include "eth_rx_consts.svh"

package eth_rx_pkg;

  // slot index into the connection table
  typedef logic [`CONN_ID_BITS-1:0] conn_id_t;

  // our own addressing, static after setup
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } conn_cfg_t;

  // remote end of a connection
  typedef struct packed {
    logic [31:0] ip;
    logic [15:0] port;
  } conn_key_t;

  // input beat, lane 0 is the first byte on the wire
  typedef struct packed {
    logic [`ETH_BUS_BYTES-1:0][7:0] data;
    logic [`ETH_BUS_BYTES-1:0]      strb;
    logic                           last;
  } rx_beat_t;

  // realigned payload beat
  typedef struct packed {
    logic [`ETH_BUS_BYTES-1:0][7:0] data;
    logic [`ETH_BUS_BYTES-1:0]      strb;
    logic                           last;
    conn_id_t                       conn_id;
    // only meaningful on the beat with last set
    logic                           length_ok;
  } pay_beat_t;

  // activate set adds the key, clear removes it
  typedef struct packed {
    conn_key_t key;
    logic      activate;
  } ctrl_req_t;

  typedef struct packed {
    logic ack;
    logic full;
  } ctrl_resp_t;

endpackage

// ==== src/eth_rx_consts.svh ====
`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// ------------------------------------------------------------
// stream geometry
// ------------------------------------------------------------
// 64-byte beat, ethernet + ipv4 + udp header fills lanes 0..41
`define ETH_BUS_BYTES     64
`define ETH_HDR_BYTES     42
// payload bytes left in the first beat after the header
`define ETH_LEFT_BYTES    22
`define ETH_UDP_HDR_BYTES 8

// protocol numbers
`define ETH_TYPE_IPV4     16'h0800
`define ETH_PROTO_UDP     8'd17

// connection table, one id per slot
`define CONN_ENTRIES      8
`define CONN_ID_BITS      3

`endif
